//--- src/zx_mem_pkg.sv
/*
 * Shared definitions for the ZX80/ZX81 memory and tape-loading subsystem.
 * Holds the memory map and loader constants, the machine enums and the
 * packed structs for the CPU bus, download port and external RAM request.
 * Modules pull it in with a wildcard import in their header.
 */

`default_nettype none

package zx_mem_pkg;

	// ==================================================================
	// memory map
	// ==================================================================
	localparam int          ROM_DEPTH     = 12288;   // boot ROM bytes
	localparam logic [13:0] ROM_ZX80_BASE = 14'h2000; // 4k ZX80 image
	localparam int          TAPE_DEPTH    = 16384;
	localparam int          TAPE_AW       = 14;
	localparam logic [15:0] RAM_BASE      = 16'h4000; // tape load area
	localparam logic [15:0] P_FILE_OFFSET = 16'd9;    // .p images skip sysvars

	// ==================================================================
	// tape loader
	// ==================================================================
	localparam logic [15:0] TRAP_ZX81 = 16'h0347; // ROM load routine entry
	localparam logic [15:0] TRAP_ZX80 = 16'h0207;
	localparam logic [15:0] END_ZX81  = 16'h03C3; // first address past routine
	localparam logic [15:0] END_ZX80  = 16'h024D;
	localparam int unsigned PATCH_LEN = 7;

	// reset and clocking
	localparam logic [15:0] RESET_HOLD  = 16'hFFFF;
	localparam int          CE_DIV_BITS = 4;

	typedef enum logic {
		MODEL_ZX80,
		MODEL_ZX81
	} model_e;

	typedef enum logic [1:0] {
		MEM_1K,
		MEM_16K,
		MEM_32K,
		MEM_64K
	} mem_size_e;

	// Z80 opcodes used by the patched loader loop
	typedef enum logic [7:0] {
		OP_NOP   = 8'h00,
		OP_JR_NC = 8'h30,
		OP_SCF   = 8'h37,
		OP_XOR_A = 8'hAF,
		OP_JP    = 8'hC3
	} patch_op_e;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;   // cpu write data
		logic        m1_n;
		logic        mreq_n;
		logic        rd_n;
		logic        wr_n;
	} cpu_bus_t;

	// index 0 is the ROM, anything else goes to tape
	typedef struct packed {
		logic        wr;
		logic [7:0]  index;
		logic [13:0] addr;
		logic [7:0]  data;
	} dl_wr_t;

	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        we;
		logic        rd;
	} ram_req_t;

	typedef struct packed {
		model_e    model;
		mem_size_e mem_size;
	} machine_cfg_t;

endpackage

`default_nettype wire

//--- src/zx_clock_enables.sv
/*
 * CPU clock-enable generator. A free-running counter on clk_sys gives
 * the positive and negative CPU phases, one of each per 16 clocks,
 * half a period apart.
 */

`default_nettype none

module zx_clock_enables
	import zx_mem_pkg::*;
(
	input  logic clk_sys,
	input  logic reset,
	output logic ce_cpu_p_o,
	output logic ce_cpu_n_o
);

	logic [CE_DIV_BITS-1:0] div_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt    <= '1; // wraps to 0 on the first free cycle
			ce_cpu_p_o <= 1'b0;
			ce_cpu_n_o <= 1'b0;
		end else begin
			div_cnt    <= div_cnt + 1'b1;
			ce_cpu_p_o <= (div_cnt == '0);
			ce_cpu_n_o <= (div_cnt == CE_DIV_BITS'(1 << (CE_DIV_BITS - 1))); // mid period
		end
	end

endmodule

`default_nettype wire

//--- src/zx_reset_ctrl.sv
/*
 * System reset sequencing. Holds the machine in reset until the boot ROM
 * has been downloaded, stretches every reload, latches the model and RAM
 * size while reset is active and flags a loaded tape image.
 */

`default_nettype none

module zx_reset_ctrl
	import zx_mem_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset_i,
	input  logic         reload_i,
	input  logic         dl_active_i,
	input  logic [7:0]   dl_index_i,
	input  machine_cfg_t cfg_i,
	output logic         sys_reset_o,
	output machine_cfg_t cfg_o,
	output logic         tape_ready_o
);

	logic        dl_active_q;
	logic        dl_end;
	logic        rom_loaded;
	logic [15:0] hold_cnt;

	assign dl_end = dl_active_q & ~dl_active_i; // falling edge of the download

	always_ff @(posedge clk_sys) begin
		dl_active_q <= dl_active_i;

		if (reset_i)
			rom_loaded <= 1'b0;
		else if (dl_end && dl_index_i == 8'd0)
			rom_loaded <= 1'b1;

		// reset stretch
		if (reset_i | reload_i | ~rom_loaded)
			hold_cnt <= RESET_HOLD;
		else if (hold_cnt != 16'd0)
			hold_cnt <= hold_cnt - 1'b1;

		sys_reset_o <= reset_i | (hold_cnt != 16'd0);

		if (reset_i | sys_reset_o)
			tape_ready_o <= 1'b0;
		else if (dl_end && dl_index_i != 8'd0)
			tape_ready_o <= 1'b1; // tape image now in the buffer
	end

	// model and RAM size only change across a reset
	always_ff @(posedge clk_sys) begin
		if (sys_reset_o)
			cfg_o <= cfg_i;
	end

endmodule

`default_nettype wire

//--- src/zx_tape_buffer.sv
/*
 * Tape image store. Download writes with a nonzero index fill it, the
 * fast loader reads it back through a registered port. Also tracks the
 * length of the image, one past the last byte written.
 */

`default_nettype none

module zx_tape_buffer
	import zx_mem_pkg::*;
(
	input  logic               clk_sys,
	input  dl_wr_t             dl_i,
	input  logic [TAPE_AW-1:0] rd_addr_i,
	output logic [7:0]         byte_o,
	output logic [TAPE_AW-1:0] length_o
);

	logic [7:0] tape_mem [TAPE_DEPTH];
	logic       tape_wr;

	assign tape_wr = dl_i.wr & (dl_i.index != 8'd0);

	// ==================================================================
	// write side, download port
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (tape_wr) begin
			tape_mem[dl_i.addr] <= dl_i.data;
			length_o            <= dl_i.addr + 1'b1;
		end
	end

	// ==================================================================
	// read side, one cycle latency
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		byte_o <= tape_mem[rd_addr_i];
	end

endmodule

`default_nettype wire

//--- src/zx_tape_loader.sv
/*
 * Fast tape loader. Traps the M1 fetch at the ROM load routine and serves
 * a small patched loop in its place (xor a / nop / jr nc / jp). While the
 * loop spins, the tape buffer is copied into RAM, one byte per positive
 * CPU phase. When the copy is done the nop turns into scf so the loop
 * exits through the jp back into the ROM.
 */

`default_nettype none

module zx_tape_loader
	import zx_mem_pkg::*;
(
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               ce_cpu_p_i,
	input  cpu_bus_t           cpu_i,
	input  machine_cfg_t       cfg_i,
	input  logic               tape_ready_i,
	input  logic [7:0]         tape_byte_i,
	input  logic [TAPE_AW-1:0] tape_length_i,
	input  logic [7:0]         dl_index_i,
	output logic [TAPE_AW-1:0] tape_addr_o,
	output logic               loading_o,
	output logic               wr_o,
	output logic [15:0]        wr_addr_o,
	output logic [7:0]         wr_data_o,
	output logic [7:0]         patch_byte_o
);

	logic [7:0]  patch_q [PATCH_LEN];
	logic        m1_q;
	logic        m1_fall;
	logic [15:0] trap_addr;
	logic [15:0] end_addr;
	logic [15:0] load_base;
	logic [15:0] patch_off;
	logic        is_zx81;

	assign is_zx81   = (cfg_i.model == MODEL_ZX81);
	assign trap_addr = is_zx81 ? TRAP_ZX81 : TRAP_ZX80;
	assign end_addr  = is_zx81 ? END_ZX81 : END_ZX80;
	assign m1_fall   = m1_q & ~cpu_i.m1_n;

	// .p images start past the system variables
	assign load_base = (dl_index_i[7:6] == 2'b01) ? RAM_BASE + P_FILE_OFFSET : RAM_BASE;

	// tape address is already one ahead when the strobe is out
	assign wr_addr_o = load_base + {2'b00, tape_addr_o} - 16'd1;
	assign wr_data_o = tape_byte_i;

	// ==================================================================
	// trap, exit and copy
	// ==================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q        <= 1'b1;
			loading_o   <= 1'b0;
			wr_o        <= 1'b0;
			tape_addr_o <= '0;
			patch_q[0]  <= OP_XOR_A;
			patch_q[1]  <= OP_NOP;
			patch_q[2]  <= OP_JR_NC;
			patch_q[3]  <= 8'hFD;   // jr back to the nop
			patch_q[4]  <= OP_JP;
			patch_q[5]  <= 8'h07;
			patch_q[6]  <= 8'h02;
		end else begin
			m1_q <= cpu_i.m1_n;
			wr_o <= 1'b0;

			if (m1_fall & tape_ready_i & (cpu_i.addr == trap_addr)) begin
				patch_q[1]  <= OP_NOP;
				patch_q[5]  <= is_zx81 ? 8'h07 : 8'h03; // jp 0207 / 0203
				tape_addr_o <= '0;
				loading_o   <= 1'b1;
			end

			// cpu left the load routine
			if (m1_fall & ((cpu_i.addr < trap_addr) | (cpu_i.addr >= end_addr)))
				loading_o <= 1'b0;

			if (loading_o & ce_cpu_p_i) begin
				if (tape_addr_o != tape_length_i) begin
					tape_addr_o <= tape_addr_o + 1'b1;
					wr_o        <= 1'b1;
				end else begin
					patch_q[1] <= OP_SCF; // carry set ends the loop
				end
			end
		end
	end

	// patch read, relative to the trap address
	always_comb begin
		patch_off = cpu_i.addr - trap_addr;
		if (patch_off < PATCH_LEN)
			patch_byte_o = patch_q[patch_off[2:0]];
		else
			patch_byte_o = 8'hFF;
	end

endmodule

`default_nettype wire

//--- src/zx_memory_map.sv
/*
 * Address decoder and boot ROM. Maps CPU accesses onto the internal ROM
 * or the external RAM for 1k, 16k, 32k and 64k machines, merges the tape
 * loader writes into the RAM request and selects the CPU read data.
 * ROM reads are registered, RAM and patch reads are combinational.
 */

`default_nettype none

module zx_memory_map
	import zx_mem_pkg::*;
(
	input  logic         clk_sys,
	input  cpu_bus_t     cpu_i,
	input  machine_cfg_t cfg_i,
	input  logic         ce_cpu_n_i,
	input  dl_wr_t       dl_i,
	input  logic         loading_i,
	input  logic         loader_wr_i,
	input  logic [15:0]  loader_addr_i,
	input  logic [7:0]   loader_data_i,
	input  logic [7:0]   patch_byte_i,
	input  logic [7:0]   ram_rdata_i,
	output ram_req_t     ram_o,
	output logic [7:0]   cpu_din_o
);

	logic [7:0]  rom_mem [ROM_DEPTH];
	logic [7:0]  rom_q;
	logic [13:0] rom_addr;
	logic        is_zx81;
	logic        a15_nf;     // A15 on a non-fetch access
	logic        ram_e_64k;
	logic        rom_e;
	logic        ram_e;
	logic        mem_rd;
	logic [15:0] cpu_ram_addr;

	assign is_zx81   = (cfg_i.model == MODEL_ZX81);
	assign a15_nf    = cpu_i.addr[15] & cpu_i.m1_n;
	assign ram_e_64k = (cfg_i.mem_size == MEM_64K) & (cpu_i.addr[13] | a15_nf);
	assign ram_e     = cpu_i.addr[14] | ram_e_64k;
	assign rom_e     = ~cpu_i.addr[14] & (~cpu_i.addr[12] | is_zx81) & ~ram_e_64k;
	assign mem_rd    = ~cpu_i.mreq_n & ~cpu_i.rd_n;

	// ==================================================================
	// boot ROM
	// ==================================================================
	assign rom_addr = is_zx81 ? {1'b0, cpu_i.addr[12:0]}
	                          : ROM_ZX80_BASE + {2'b00, cpu_i.addr[11:0]};

	always_ff @(posedge clk_sys) begin
		if (dl_i.wr && dl_i.index == 8'd0)
			rom_mem[dl_i.addr] <= dl_i.data;
	end

	always_ff @(posedge clk_sys) begin
		rom_q <= rom_mem[rom_addr];
	end

	// ==================================================================
	// RAM request
	// ==================================================================
	always_comb begin
		case (cfg_i.mem_size)
			MEM_1K:  cpu_ram_addr = RAM_BASE + {6'd0, cpu_i.addr[9:0]};
			MEM_16K: cpu_ram_addr = RAM_BASE + {2'b00, cpu_i.addr[13:0]};
			MEM_32K: cpu_ram_addr = RAM_BASE + {1'b0, a15_nf, cpu_i.addr[13:0]};
			default: cpu_ram_addr = {a15_nf, cpu_i.addr[14:0]}; // 64k
		endcase
	end

	always_comb begin
		if (loader_wr_i) begin // tape copy wins
			ram_o.addr  = loader_addr_i;
			ram_o.wdata = loader_data_i;
			ram_o.we    = 1'b1;
			ram_o.rd    = 1'b0;
		end else begin
			ram_o.addr  = cpu_ram_addr;
			ram_o.wdata = cpu_i.dout;
			ram_o.we    = ~cpu_i.wr_n & ~cpu_i.mreq_n & ram_e;
			ram_o.rd    = ram_e & mem_rd & ~ce_cpu_n_i & ~loading_i;
		end
	end

	// cpu read data
	always_comb begin
		if (!mem_rd)
			cpu_din_o = 8'hFF;
		else if (rom_e)
			cpu_din_o = loading_i ? patch_byte_i : rom_q;
		else if (ram_e)
			cpu_din_o = ram_rdata_i;
		else
			cpu_din_o = 8'hFF; // unmapped ZX80 hole
	end

endmodule

`default_nettype wire

//--- src/zx_mem_top.sv
/*
 * Top of the memory and tape-loading subsystem. Connects the CPU bus, the
 * download port and the external RAM request to the clock enables, reset
 * sequencing, tape buffer, fast loader and address decoder.
 */

`default_nettype none

module zx_mem_top
	import zx_mem_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset_i,
	input  logic         reload_i,
	input  logic         dl_active_i,
	input  dl_wr_t       dl_i,
	input  machine_cfg_t cfg_i,
	input  cpu_bus_t     cpu_i,
	input  logic [7:0]   ram_rdata_i,
	output logic [7:0]   cpu_din_o,
	output ram_req_t     ram_o,
	output logic         ce_cpu_p_o,
	output logic         ce_cpu_n_o,
	output logic         sys_reset_o,
	output logic         tape_ready_o,
	output logic         loading_o
);

	machine_cfg_t       cfg;
	logic [TAPE_AW-1:0] tape_addr;
	logic [TAPE_AW-1:0] tape_length;
	logic [7:0]         tape_byte;
	logic               loader_wr;
	logic [15:0]        loader_addr;
	logic [7:0]         loader_data;
	logic [7:0]         patch_byte;

	zx_clock_enables u_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (sys_reset_o),
		.ce_cpu_p_o (ce_cpu_p_o),
		.ce_cpu_n_o (ce_cpu_n_o)
	);

	zx_reset_ctrl u_reset_ctrl (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.reload_i     (reload_i),
		.dl_active_i  (dl_active_i),
		.dl_index_i   (dl_i.index),
		.cfg_i        (cfg_i),
		.sys_reset_o  (sys_reset_o),
		.cfg_o        (cfg),
		.tape_ready_o (tape_ready_o)
	);

	zx_tape_buffer u_tape_buffer (
		.clk_sys   (clk_sys),
		.dl_i      (dl_i),
		.rd_addr_i (tape_addr),
		.byte_o    (tape_byte),
		.length_o  (tape_length)
	);

	zx_tape_loader u_tape_loader (
		.clk_sys       (clk_sys),
		.reset         (sys_reset_o),
		.ce_cpu_p_i    (ce_cpu_p_o),
		.cpu_i         (cpu_i),
		.cfg_i         (cfg),
		.tape_ready_i  (tape_ready_o),
		.tape_byte_i   (tape_byte),
		.tape_length_i (tape_length),
		.dl_index_i    (dl_i.index),
		.tape_addr_o   (tape_addr),
		.loading_o     (loading_o),
		.wr_o          (loader_wr),
		.wr_addr_o     (loader_addr),
		.wr_data_o     (loader_data),
		.patch_byte_o  (patch_byte)
	);

	zx_memory_map u_memory_map (
		.clk_sys       (clk_sys),
		.cpu_i         (cpu_i),
		.cfg_i         (cfg),
		.ce_cpu_n_i    (ce_cpu_n_o),
		.dl_i          (dl_i),
		.loading_i     (loading_o),
		.loader_wr_i   (loader_wr),
		.loader_addr_i (loader_addr),
		.loader_data_i (loader_data),
		.patch_byte_i  (patch_byte),
		.ram_rdata_i   (ram_rdata_i),
		.ram_o         (ram_o),
		.cpu_din_o     (cpu_din_o)
	);

endmodule

`default_nettype wire

//--- dv/tb_zx_mem_top.sv
/*
 * Directed testbench for the ZX80/ZX81 memory and tape-loading subsystem.
 * Plays the CPU bus and the download port and models the external RAM.
 * Covers reset sequencing, ROM readback per model, the RAM map for every
 * memory size and fast .p/.o tape loads with the loader exit.
 */

`default_nettype none

module tb_zx_mem_top
	import zx_mem_pkg::*;
();

	logic         clk_sys;
	logic         reset_i;
	logic         reload_i;
	logic         dl_active_i;
	dl_wr_t       dl_i;
	machine_cfg_t cfg_i;
	cpu_bus_t     cpu_i;
	logic [7:0]   ram_rdata_i;
	logic [7:0]   cpu_din_o;
	ram_req_t     ram_o;
	logic         ce_cpu_p_o;
	logic         ce_cpu_n_o;
	logic         sys_reset_o;
	logic         tape_ready_o;
	logic         loading_o;

	logic [7:0]  ram_model [65536];
	logic [7:0]  rom_ref [ROM_DEPTH];
	logic [7:0]  tape_ref [64];
	logic [15:0] sample_addr [6] = '{16'h4123, 16'h7FFE, 16'h2345, 16'hC010, 16'h8005, 16'h0100};
	logic [7:0]  patch_ref [7] = '{8'hAF, 8'h00, 8'h30, 8'hFD, 8'hC3, 8'h07, 8'h02};
	int          errors;
	int          seed;
	int          loader_writes;
	int          misplaced_writes;
	bit          ce_p_last;

	zx_mem_top DUT (
		.clk_sys      (clk_sys),
		.reset_i      (reset_i),
		.reload_i     (reload_i),
		.dl_active_i  (dl_active_i),
		.dl_i         (dl_i),
		.cfg_i        (cfg_i),
		.cpu_i        (cpu_i),
		.ram_rdata_i  (ram_rdata_i),
		.cpu_din_o    (cpu_din_o),
		.ram_o        (ram_o),
		.ce_cpu_p_o   (ce_cpu_p_o),
		.ce_cpu_n_o   (ce_cpu_n_o),
		.sys_reset_o  (sys_reset_o),
		.tape_ready_o (tape_ready_o),
		.loading_o    (loading_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ==================================================================
	// external RAM model and loader write monitor
	// ==================================================================
	assign ram_rdata_i = ram_model[ram_o.addr]; // asynchronous read

	always @(posedge clk_sys) begin
		if (reset_i) begin
			for (int i = 0; i < 65536; i++)
				ram_model[i] <= 8'(i) ^ 8'(i >> 8) ^ 8'h5A; // fill depends on whole address
		end else if (ram_o.we) begin
			ram_model[ram_o.addr] <= ram_o.wdata;
		end
	end

	always @(negedge clk_sys) begin
		if (ram_o.we && loading_o) begin
			loader_writes++;
			if (!ce_p_last)
				misplaced_writes++; // strobe must trail ce_cpu_p by one cycle
		end
		ce_p_last = ce_cpu_p_o;
	end

	// ==================================================================
	// helpers
	// ==================================================================
	task automatic report_mismatch(input string name, input logic [15:0] exp,
			input logic [15:0] act);
		errors++;
		$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("%0t %s", $time, msg);
	endtask

	// strobes are active low, in the order m1_n, mreq_n, rd_n, wr_n
	task automatic set_bus(input logic [15:0] addr, input logic [7:0] dout, input logic m1_n,
			input logic mreq_n, input logic rd_n, input logic wr_n);
		@(posedge clk_sys);
		#1;
		cpu_i.addr   = addr;
		cpu_i.dout   = dout;
		cpu_i.m1_n   = m1_n;
		cpu_i.mreq_n = mreq_n;
		cpu_i.rd_n   = rd_n;
		cpu_i.wr_n   = wr_n;
	endtask

	task automatic download_image(input logic [7:0] index, input int count);
		@(posedge clk_sys);
		#1;
		dl_active_i = 1'b1;
		dl_i.index  = index; // held after the download, the loader reads it
		for (int i = 0; i < count; i++) begin
			@(posedge clk_sys);
			#1;
			dl_i.wr   = 1'b1;
			dl_i.addr = 14'(i);
			dl_i.data = (index == 8'h00) ? rom_ref[i] : tape_ref[i];
		end
		@(posedge clk_sys);
		#1;
		dl_i.wr = 1'b0;
		@(posedge clk_sys);
		#1;
		dl_active_i = 1'b0;
	endtask

	task automatic wait_reset_release();
		int n;
		bit strobe_seen;
		n = 0;
		strobe_seen = 0;
		@(negedge clk_sys);
		while (sys_reset_o && n < int'(RESET_HOLD) + 1000) begin
			if (ce_cpu_p_o || ce_cpu_n_o || loading_o || tape_ready_o || ram_o.we || ram_o.rd)
				strobe_seen = 1;
			@(negedge clk_sys);
			n++;
		end
		if (sys_reset_o)
			report_failure("timeout waiting for sys_reset_o to fall");
		if (strobe_seen)
			report_failure("an enable or strobe was active during system reset");
	endtask

	task automatic reload_machine(input machine_cfg_t cfg);
		int n;
		set_bus(16'h0000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1);
		cfg_i    = cfg;
		reload_i = 1'b1;
		@(posedge clk_sys);
		#1;
		reload_i = 1'b0;
		n = 0;
		@(negedge clk_sys);
		while (!sys_reset_o && n < 10) begin
			@(negedge clk_sys);
			n++;
		end
		if (!sys_reset_o)
			report_failure("sys_reset_o did not rise after reload");
		wait_reset_release();
	endtask

	task automatic wait_tape_ready();
		int n;
		n = 0;
		@(negedge clk_sys);
		while (!tape_ready_o && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (!tape_ready_o)
			report_failure("timeout waiting for tape_ready_o");
	endtask

	task automatic wait_loading(input logic level);
		int n;
		n = 0;
		@(negedge clk_sys);
		while (loading_o !== level && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		if (loading_o !== level)
			report_failure($sformatf("timeout waiting for loading_o to become %0d", level));
	endtask

	// polls the nop slot until it turns into scf
	task automatic wait_copy_done(input logic [15:0] addr, input int limit);
		int n;
		set_bus(addr, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
		n = 0;
		@(negedge clk_sys);
		while (cpu_din_o !== 8'h37 && n < limit) begin
			@(negedge clk_sys);
			n++;
		end
		if (cpu_din_o !== 8'h37)
			report_failure("timeout waiting for the end of the tape copy");
	endtask

	task automatic check_tape_copy(input logic [15:0] base, input int len, input int w0,
			input int m0);
		logic [15:0] a;
		if (loader_writes - w0 != len)
			report_mismatch("loader write count", 16'(len), 16'(loader_writes - w0));
		if (misplaced_writes != m0)
			report_failure("loader write strobe did not follow ce_cpu_p_o by one cycle");
		for (int k = 0; k < len; k++) begin
			a = base + 16'(k);
			if (ram_model[a] !== tape_ref[k])
				report_mismatch($sformatf("ram[%h]", a), {8'h00, tape_ref[k]},
					{8'h00, ram_model[a]});
		end
	endtask

	function automatic logic ram_selected(input logic [15:0] a, input logic m1_n,
			input mem_size_e size);
		logic upper;
		upper = a[15] && m1_n; // A15 only counts outside a fetch
		return a[14] || (size == MEM_64K && (a[13] || upper));
	endfunction

	function automatic logic [15:0] ram_address(input logic [15:0] a, input logic m1_n,
			input mem_size_e size);
		logic upper;
		upper = a[15] && m1_n;
		case (size)
			MEM_1K:  return 16'h4000 + (a & 16'h03FF);
			MEM_16K: return 16'h4000 + (a & 16'h3FFF);
			MEM_32K: return 16'h4000 + (upper ? 16'h4000 : 16'h0000) + (a & 16'h3FFF);
			default: return (upper ? 16'h8000 : 16'h0000) | (a & 16'h7FFF);
		endcase
	endfunction

	// ==================================================================
	// tests
	// ==================================================================
	task automatic check_reset_sequence();
		int last_p;
		int n_p;
		int n_n;
		for (int i = 0; i < ROM_DEPTH; i++)
			rom_ref[i] = 8'($random(seed));
		@(negedge clk_sys);
		if (sys_reset_o !== 1'b1)
			report_mismatch("sys_reset_o", 16'h1, {15'h0, sys_reset_o});
		download_image(8'h00, ROM_DEPTH);
		@(negedge clk_sys);
		if (sys_reset_o !== 1'b1) // still stretched after the ROM download
			report_mismatch("sys_reset_o", 16'h1, {15'h0, sys_reset_o});
		wait_reset_release();
		last_p = -1;
		n_p = 0;
		n_n = 0;
		for (int cyc = 0; cyc < 64; cyc++) begin
			@(negedge clk_sys);
			if (ce_cpu_p_o) begin
				if (last_p >= 0 && cyc - last_p != 16)
					report_mismatch("ce_cpu_p_o period", 16'd16, 16'(cyc - last_p));
				last_p = cyc;
				n_p++;
			end
			if (ce_cpu_n_o) begin
				n_n++;
				if (last_p >= 0 && cyc - last_p != 8)
					report_mismatch("ce_cpu_n_o offset", 16'd8, 16'(cyc - last_p));
			end
		end
		if (n_p < 3 || n_n < 3)
			report_failure("too few clock-enable pulses after reset");
	endtask

	task automatic rom_readback();
		logic [15:0] a;
		logic [7:0]  exp;
		for (int i = 0; i < 8; i++) begin
			a = 16'($random(seed)) & 16'h1FFF;
			set_bus(a, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
			@(posedge clk_sys); // registered ROM read
			@(negedge clk_sys);
			exp = rom_ref[a[13:0]];
			if (cpu_din_o !== exp)
				report_mismatch("cpu_din_o", {8'h00, exp}, {8'h00, cpu_din_o});
		end
		reload_machine('{model: MODEL_ZX80, mem_size: MEM_1K});
		for (int i = 0; i < 8; i++) begin
			a = 16'($random(seed)) & 16'h0FFF;
			set_bus(a, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
			@(posedge clk_sys);
			@(negedge clk_sys);
			exp = rom_ref[14'h2000 + a[13:0]];
			if (cpu_din_o !== exp)
				report_mismatch("cpu_din_o", {8'h00, exp}, {8'h00, cpu_din_o});
		end
		set_bus(16'h00FE, 8'h00, 1'b1, 1'b1, 1'b0, 1'b1); // i/o read
		@(negedge clk_sys);
		if (cpu_din_o !== 8'hFF)
			report_mismatch("cpu_din_o", 16'h00FF, {8'h00, cpu_din_o});
	endtask

	task automatic ram_mapping();
		mem_size_e   size;
		logic [15:0] a;
		logic [7:0]  d;
		logic        sel;
		for (int s = 0; s < 4; s++) begin
			size = mem_size_e'(s);
			reload_machine('{model: MODEL_ZX81, mem_size: size});
			for (int i = 0; i < 6; i++) begin
				a   = sample_addr[i];
				d   = 8'($random(seed));
				sel = ram_selected(a, 1'b1, size);
				set_bus(a, d, 1'b1, 1'b0, 1'b1, 1'b0);
				@(negedge clk_sys);
				if (ram_o.we !== sel)
					report_mismatch("ram_o.we", {15'h0, sel}, {15'h0, ram_o.we});
				if (sel && ram_o.addr !== ram_address(a, 1'b1, size))
					report_mismatch("ram_o.addr", ram_address(a, 1'b1, size), ram_o.addr);
				if (sel && ram_o.wdata !== d)
					report_mismatch("ram_o.wdata", {8'h00, d}, {8'h00, ram_o.wdata});
				set_bus(a, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
				@(negedge clk_sys);
				if (ram_o.rd !== (sel && !ce_cpu_n_o))
					report_mismatch("ram_o.rd", {15'h0, sel && !ce_cpu_n_o}, {15'h0, ram_o.rd});
				if (sel && cpu_din_o !== d) // read back through ram_rdata_i
					report_mismatch("cpu_din_o", {8'h00, d}, {8'h00, cpu_din_o});
			end
			set_bus(16'h8005, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1); // fetch from upper half
			@(negedge clk_sys);
			if (ram_o.rd !== (ram_selected(16'h8005, 1'b0, size) && !ce_cpu_n_o))
				report_mismatch("ram_o.rd", 16'h0, {15'h0, ram_o.rd});
		end
		set_bus(16'h0000, 8'h00, 1'b1, 1'b1, 1'b1, 1'b1); // end the fetch, bus idle
	endtask

	task automatic p_tape_load();
		int len;
		int w0;
		int m0;
		len = 20;
		for (int k = 0; k < len; k++)
			tape_ref[k] = 8'($random(seed));
		download_image(8'h41, len);
		wait_tape_ready();
		if (loading_o !== 1'b0)
			report_mismatch("loading_o", 16'h0, {15'h0, loading_o});
		w0 = loader_writes;
		m0 = misplaced_writes;
		set_bus(TRAP_ZX81, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1);
		wait_loading(1'b1);
		for (int i = 0; i < 7; i++) begin
			set_bus(TRAP_ZX81 + 16'(i), 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
			@(negedge clk_sys);
			if (cpu_din_o !== patch_ref[i])
				report_mismatch("cpu_din_o", {8'h00, patch_ref[i]}, {8'h00, cpu_din_o});
		end
		wait_copy_done(16'h0348, len * 16 + 200);
		check_tape_copy(16'h4009, len, w0, m0); // .p skips the system variables
	endtask

	task automatic o_tape_load_and_exit();
		int len;
		int w0;
		int m0;
		logic [7:0] exp;
		reload_machine('{model: MODEL_ZX80, mem_size: MEM_16K});
		len = 12;
		for (int k = 0; k < len; k++)
			tape_ref[k] = 8'($random(seed));
		download_image(8'h01, len);
		wait_tape_ready();
		w0 = loader_writes;
		m0 = misplaced_writes;
		set_bus(TRAP_ZX80, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1);
		wait_loading(1'b1);
		set_bus(TRAP_ZX80 + 16'd5, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
		@(negedge clk_sys);
		if (cpu_din_o !== 8'h03) // jp 0203 on the ZX80
			report_mismatch("cpu_din_o", 16'h0003, {8'h00, cpu_din_o});
		wait_copy_done(16'h0208, len * 16 + 200);
		check_tape_copy(16'h4000, len, w0, m0);
		set_bus(16'h0300, 8'h00, 1'b0, 1'b0, 1'b0, 1'b1); // fetch outside the routine
		wait_loading(1'b0);
		set_bus(TRAP_ZX80, 8'h00, 1'b1, 1'b0, 1'b0, 1'b1);
		@(posedge clk_sys);
		@(negedge clk_sys);
		exp = rom_ref[14'h2207];
		if (cpu_din_o !== exp)
			report_mismatch("cpu_din_o", {8'h00, exp}, {8'h00, cpu_din_o});
	endtask

	// ==================================================================
	// main sequence
	// ==================================================================
	initial begin
		seed        = 32'h51cd_527f;
		errors      = 0;
		reset_i     = 1'b1;
		reload_i    = 1'b0;
		dl_active_i = 1'b0;
		dl_i        = '0;
		cfg_i       = '{model: MODEL_ZX81, mem_size: MEM_16K};
		cpu_i       = '{addr: 16'h0000, dout: 8'h00, m1_n: 1'b1, mreq_n: 1'b1,
		                rd_n: 1'b1, wr_n: 1'b1};
		repeat (10) @(posedge clk_sys);
		#1 reset_i = 1'b0;

		check_reset_sequence();
		rom_readback();
		ram_mapping();
		p_tape_load();
		o_tape_load_and_exit();

		$display("tests done, errors: %0d", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- project.f
src/zx_mem_pkg.sv
src/zx_clock_enables.sv
src/zx_reset_ctrl.sv
src/zx_tape_buffer.sv
src/zx_tape_loader.sv
src/zx_memory_map.sv
src/zx_mem_top.sv
dv/tb_zx_mem_top.sv

//--- run.sh
#!/usr/bin/env bash
# builds and runs the testbench with Verilator, result taken from the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary -Wno-fatal --top-module tb_zx_mem_top -f project.f -o tb_zx_mem_top
./obj_dir/tb_zx_mem_top | tee sim.log

if grep -q "STATUS: FAIL" sim.log; then
	exit 1
fi
exit 0
